//--- fm_bus_if.sv
//----------------------------------------------------------------------------
// FM register bus; addr 0 is the index port, 1 the data port
//----------------------------------------------------------------------------
`timescale 1ns/1ps

interface fm_bus_if;

    logic       addr;                             // 0 index, 1 data
    logic [7:0] din;
    logic       we;
    logic [7:0] dout;                             // status on addr 0, FFh on addr 1

    modport host (
        output addr,
        output din,
        output we,
        input  dout
    );

    modport chip (
        input  addr,
        input  din,
        input  we,
        output dout
    );

endinterface

//--- fm_port_arbiter.sv
//----------------------------------------------------------------------------
// 220h+0/1/8/9 and 388h+0/1 share the FM bus; 220h wins, the loser is lost.
// status is only visible in a cycle with no FM write
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module fm_port_arbiter (
    input  logic [3:0] io_address,
    input  logic       io_write,
    input  logic [7:0] io_writedata,
    input  logic [1:0] fm_address,
    input  logic       fm_write,
    input  logic [7:0] fm_writedata,
    input  logic [7:0] dsp_readdata,
    output logic [7:0] io_readdata,
    output logic [7:0] fm_readdata,
    fm_bus_if.host     bus
);

    logic io_we;
    logic fm_we;

    assign io_we = io_write && io_address[2:1] == 2'b00;     // offsets 0,1,8,9
    assign fm_we = fm_write && !fm_address[1] && !io_we;      // 388h+0/1 at lower priority

    assign bus.we   = io_we || fm_we;
    assign bus.addr = io_we ? io_address[0] : (fm_we ? fm_address[0] : 1'b0);  // idle on status
    assign bus.din  = io_we ? io_writedata : fm_writedata;

    assign io_readdata = (io_address == 4'h8) ? bus.dout : dsp_readdata;
    assign fm_readdata = (fm_address == 2'd0) ? bus.dout : 8'hFF;

endmodule

//--- opl_timer_tone.sv
//----------------------------------------------------------------------------
// FM chip stand-in: register file, timer 1 and one panned square voice;
// no operators, no timer 2, and a period_80us of 0 gives a slow tick
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module opl_timer_tone (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [12:0] period_80us,
    fm_bus_if.chip      bus,
    output logic [15:0] fm_l,
    output logic [15:0] fm_r
);
    import sound_pkg::*;

    logic [7:0]  index;                           // last value at the index port
    logic [7:0]  t1_preset;
    logic [7:0]  t1_count;
    logic        t1_run;
    logic        t1_flag;
    logic [9:0]  fnum;
    logic        key_on;
    logic [1:0]  pan;                             // C0h bits 5:4, right/left
    logic [12:0] tick_cnt;
    logic        tick;
    logic [9:0]  half_cnt;
    logic        phase;                           // 1 is the negative half
    logic        data_wr;
    logic [15:0] level;

    assign data_wr = bus.we && bus.addr;

    //------------------------------------------------------------------------
    // register file
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index     <= '0;
            t1_preset <= '0;
            t1_run    <= 1'b0;
            fnum      <= '0;
            key_on    <= 1'b0;
            pan       <= '0;
        end else if (bus.we && !bus.addr) begin
            index <= bus.din;
        end else if (data_wr) begin
            case (index)
                OPL_REG_TIMER1: t1_preset <= bus.din;
                OPL_REG_CTRL: begin
                    if (!bus.din[7]) t1_run <= bus.din[0];   // bit 7 write only clears
                end
                OPL_REG_FNUM_LO: fnum[7:0] <= bus.din;
                OPL_REG_KEY_FNUM_HI: begin
                    key_on    <= bus.din[5];
                    fnum[9:8] <= bus.din[1:0];
                end
                OPL_REG_PAN: pan <= bus.din[5:4];
                default: ;                        // unmodelled register
            endcase
        end
    end

    // 80 us tick
    assign tick = tick_cnt == '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) tick_cnt <= '0;
        else if (tick) tick_cnt <= period_80us - 13'd1;
        else tick_cnt <= tick_cnt - 13'd1;
    end

    // timer 1, held at its preset while stopped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t1_count <= '0;
            t1_flag  <= 1'b0;
        end else begin
            if (!t1_run) begin
                t1_count <= t1_preset;
            end else if (tick) begin
                if (t1_count == 8'hFF) begin
                    t1_count <= t1_preset;        // overflow, reload
                    t1_flag  <= 1'b1;
                end else begin
                    t1_count <= t1_count + 8'd1;
                end
            end
            if (data_wr && index == OPL_REG_CTRL && bus.din[7]) t1_flag <= 1'b0;
        end
    end

    assign bus.dout = bus.addr ? 8'hFF : {t1_flag, t1_flag, 6'd0};

    //------------------------------------------------------------------------
    // square voice, fnum+1 cycles per half period
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_cnt <= '0;
            phase    <= 1'b0;
        end else if (!key_on) begin
            half_cnt <= '0;
            phase    <= 1'b0;
        end else if (half_cnt == fnum) begin
            half_cnt <= '0;
            phase    <= !phase;
        end else begin
            half_cnt <= half_cnt + 10'd1;
        end
    end

    assign level = !key_on ? 16'd0 : (phase ? -FM_TONE_LEVEL : FM_TONE_LEVEL);
    assign fm_l  = pan[0] ? level : 16'd0;
    assign fm_r  = pan[1] ? level : 16'd0;

endmodule

//--- sound.f
sound_pkg.sv
fm_bus_if.sv
sound_dsp.sv
opl_timer_tone.sv
fm_port_arbiter.sv
sound_mixer.sv
sound.sv
tb_sound.sv

//--- sound.sv
//----------------------------------------------------------------------------
// sound card top with the DSP at 220h and FM at 220h/388h; one clock only
// and no MPU-401
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module sound (
    input  logic        clk,
    input  logic        rst_n,
    output logic        irq,
    input  logic [3:0]  io_address,
    input  logic        io_read,
    input  logic        io_write,
    input  logic [7:0]  io_writedata,
    output logic [7:0]  io_readdata,
    input  logic [1:0]  fm_address,
    input  logic        fm_read,
    input  logic        fm_write,
    input  logic [7:0]  fm_writedata,
    output logic [7:0]  fm_readdata,
    output logic        dma_soundblaster_req,
    input  logic        dma_soundblaster_ack,
    input  logic        dma_soundblaster_terminal,
    input  logic [7:0]  dma_soundblaster_readdata,
    output logic [15:0] sample_l,
    output logic [15:0] sample_r,
    input  logic [8:0]  mgmt_address,
    input  logic        mgmt_write,
    input  logic [31:0] mgmt_writedata
);
    import sound_pkg::*;

    logic [12:0] period_80us;                     // clk cycles per timer tick
    logic [7:0]  dsp_readdata;
    logic        sample_disabled;
    logic        sample_do;
    logic [7:0]  sample_value;
    logic [15:0] fm_l;
    logic [15:0] fm_r;

    fm_bus_if fm_bus ();

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_80us <= PERIOD_80US_RESET;
        end else if (mgmt_write && mgmt_address == MGMT_ADDR_80US) begin
            period_80us <= mgmt_writedata[12:0];
        end
    end

    //------------------------------------------------------------------------
    // blocks
    //------------------------------------------------------------------------
    sound_dsp i_dsp (
        .clk             (clk),
        .rst_n           (rst_n),
        .io_address      (io_address),
        .io_read         (io_read),
        .io_write        (io_write),
        .io_writedata    (io_writedata),
        .dsp_readdata    (dsp_readdata),
        .irq             (irq),
        .dma_req         (dma_soundblaster_req),
        .dma_ack         (dma_soundblaster_ack),
        .dma_terminal    (dma_soundblaster_terminal),
        .dma_readdata    (dma_soundblaster_readdata),
        .mgmt_address    (mgmt_address),
        .mgmt_write      (mgmt_write),
        .mgmt_writedata  (mgmt_writedata),
        .sample_disabled (sample_disabled),
        .sample_do       (sample_do),
        .sample_value    (sample_value)
    );

    fm_port_arbiter i_arbiter (
        .io_address   (io_address),
        .io_write     (io_write),
        .io_writedata (io_writedata),
        .fm_address   (fm_address),
        .fm_write     (fm_write),
        .fm_writedata (fm_writedata),
        .dsp_readdata (dsp_readdata),
        .io_readdata  (io_readdata),
        .fm_readdata  (fm_readdata),
        .bus          (fm_bus.host)
    );

    opl_timer_tone i_opl (
        .clk         (clk),
        .rst_n       (rst_n),
        .period_80us (period_80us),
        .bus         (fm_bus.chip),
        .fm_l        (fm_l),
        .fm_r        (fm_r)
    );

    sound_mixer i_mixer (
        .clk             (clk),
        .rst_n           (rst_n),
        .sample_disabled (sample_disabled),
        .sample_do       (sample_do),
        .sample_value    (sample_value),
        .fm_l            (fm_l),
        .fm_r            (fm_r),
        .sample_l        (sample_l),
        .sample_r        (sample_r)
    );

endmodule

//--- sound_dsp.sv
//----------------------------------------------------------------------------
// DSP at 220h: reset handshake, direct dac, speaker and single-cycle dma8;
// commands other than 10h/14h/D1h/D3h are ignored, none accepted during dma
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module sound_dsp (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  io_address,
    input  logic        io_read,
    input  logic        io_write,
    input  logic [7:0]  io_writedata,
    output logic [7:0]  dsp_readdata,
    output logic        irq,
    output logic        dma_req,
    input  logic        dma_ack,
    input  logic        dma_terminal,
    input  logic [7:0]  dma_readdata,
    input  logic [8:0]  mgmt_address,
    input  logic        mgmt_write,
    input  logic [31:0] mgmt_writedata,
    output logic        sample_disabled,
    output logic        sample_do,
    output logic [7:0]  sample_value
);
    import sound_pkg::*;

    dsp_state_e  state;
    logic        speaker_on;
    logic        reset_armed;                     // 1 seen at offset 6
    logic        read_ready;                      // AAh waiting at offset A
    logic [15:0] sample_period;                   // clk cycles between requests
    logic [15:0] period_cnt;
    logic [15:0] dma_left;                        // bytes still due after this one
    logic        cmd_wr;
    logic        reset_wr;
    logic        take_dac;
    logic        take_dma;

    assign cmd_wr   = io_write && io_address == 4'hC;
    assign reset_wr = io_write && io_address == 4'h6;
    assign take_dac = cmd_wr && state == DSP_DAC_BYTE;
    assign take_dma = dma_req && dma_ack;

    assign sample_disabled = !speaker_on;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_period <= SAMPLE_PERIOD_RESET;
        end else if (mgmt_write && mgmt_address == MGMT_ADDR_SAMPLE_PERIOD) begin
            sample_period <= mgmt_writedata[15:0];
        end
    end

    // sample byte, from the dac write or the dma ack
    always_ff @(posedge clk) begin
        if (take_dac) begin
            sample_value <= io_writedata;
        end else if (take_dma) begin
            sample_value <= dma_readdata;
        end
    end

    //------------------------------------------------------------------------
    // command sequencer
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= DSP_IDLE;
            speaker_on  <= 1'b0;
            reset_armed <= 1'b0;
            read_ready  <= 1'b0;
            irq         <= 1'b0;
            dma_req     <= 1'b0;
            sample_do   <= 1'b0;
            period_cnt  <= '0;
            dma_left    <= '0;
        end else begin
            sample_do <= speaker_on && (take_dac || take_dma);   // muted bytes dropped
            if (io_read && io_address == 4'hA) read_ready <= 1'b0;
            if (io_read && io_address == 4'hE) irq <= 1'b0;     // irq ack
            if (reset_wr) reset_armed <= io_writedata[0];

            if (reset_wr && reset_armed && !io_writedata[0]) begin
                read_ready <= 1'b1;               // 1 then 0 completes the reset
                state      <= DSP_IDLE;
                dma_req    <= 1'b0;
            end else begin
                unique case (state)
                    DSP_IDLE: begin
                        if (cmd_wr) begin
                            case (dsp_cmd_e'(io_writedata))
                                DSP_CMD_DAC:     state <= DSP_DAC_BYTE;
                                DSP_CMD_DMA8:    state <= DSP_LEN_LO;
                                DSP_CMD_SPK_ON:  speaker_on <= 1'b1;
                                DSP_CMD_SPK_OFF: speaker_on <= 1'b0;
                                default:         state <= DSP_IDLE;
                            endcase
                        end
                    end
                    DSP_DAC_BYTE: begin
                        if (cmd_wr) state <= DSP_IDLE;    // byte taken via take_dac
                    end
                    DSP_LEN_LO: begin
                        if (cmd_wr) begin
                            dma_left[7:0] <= io_writedata;
                            state         <= DSP_LEN_HI;
                        end
                    end
                    DSP_LEN_HI: begin
                        if (cmd_wr) begin
                            dma_left[15:8] <= io_writedata;
                            period_cnt     <= sample_period;
                            state          <= DSP_DMA_RUN;
                        end
                    end
                    DSP_DMA_RUN: begin
                        if (take_dma) begin
                            dma_req    <= 1'b0;
                            period_cnt <= sample_period;   // pacing restarts at the ack
                            dma_left   <= dma_left - 16'd1;
                            if (dma_left == '0 || dma_terminal) begin
                                state <= DSP_IDLE;
                                irq   <= 1'b1;
                            end
                        end else if (!dma_req) begin
                            if (period_cnt == '0) dma_req <= 1'b1;
                            else period_cnt <= period_cnt - 16'd1;
                        end
                    end
                    default: state <= DSP_IDLE;
                endcase
            end
        end
    end

    always_comb begin
        case (io_address)
            4'hA:    dsp_readdata = read_ready ? DSP_RESET_ACK : 8'hFF;
            4'hC:    dsp_readdata = 8'h00;        // write buffer always free
            4'hE:    dsp_readdata = {read_ready, 7'h7F};
            default: dsp_readdata = 8'hFF;
        endcase
    end

    a_no_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state == DSP_IDLE |-> !dma_req);
    a_no_sample_muted: assert property (@(posedge clk) disable iff (!rst_n)
        sample_do |-> !sample_disabled);

endmodule

//--- sound_mixer.sv
//----------------------------------------------------------------------------
// DSP quarter plus FM half per channel; the sum wraps, it does not saturate
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module sound_mixer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sample_disabled,
    input  logic        sample_do,
    input  logic [7:0]  sample_value,
    input  logic [15:0] fm_l,
    input  logic [15:0] fm_r,
    output logic [15:0] sample_l,
    output logic [15:0] sample_r
);

    logic [15:0] sample_dsp;                      // signed, byte repeated low
    logic [15:0] dsp_quarter;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_dsp <= '0;
        end else if (sample_disabled) begin
            sample_dsp <= '0;                     // speaker off is silence
        end else if (sample_do) begin
            sample_dsp <= {~sample_value[7], sample_value[6:0], sample_value};
        end
    end

    assign dsp_quarter = {{2{sample_dsp[15]}}, sample_dsp[15:2]};

    assign sample_l = dsp_quarter + {fm_l[15], fm_l[15:1]};
    assign sample_r = dsp_quarter + {fm_r[15], fm_r[15:1]};

endmodule

//--- sound_pkg.sv
//----------------------------------------------------------------------------
// shared DSP opcodes, FM register indices and management map; only the
// four DSP commands and the timer 1 / tone registers are decoded
//----------------------------------------------------------------------------
package sound_pkg;

    // DSP commands written to 22Ch
    typedef enum logic [7:0] {
        DSP_CMD_DAC     = 8'h10,                  // direct 8-bit dac, one byte follows
        DSP_CMD_DMA8    = 8'h14,                  // single-cycle 8-bit dma, length follows
        DSP_CMD_SPK_ON  = 8'hD1,
        DSP_CMD_SPK_OFF = 8'hD3
    } dsp_cmd_e;

    typedef enum logic [2:0] {
        DSP_IDLE,
        DSP_DAC_BYTE,                             // waiting for the dac byte
        DSP_LEN_LO,
        DSP_LEN_HI,
        DSP_DMA_RUN
    } dsp_state_e;

    localparam logic [7:0]  DSP_RESET_ACK       = 8'hAA;
    localparam logic [12:0] PERIOD_80US_RESET   = 13'd2400;  // 80 us at 30 MHz
    localparam logic [15:0] SAMPLE_PERIOD_RESET = 16'd1042;

    localparam logic [8:0]  MGMT_ADDR_SAMPLE_PERIOD = 9'd0;
    localparam logic [8:0]  MGMT_ADDR_80US          = 9'd256;

    // FM register file indices
    localparam logic [7:0]  OPL_REG_TIMER1      = 8'h02;
    localparam logic [7:0]  OPL_REG_CTRL        = 8'h04;
    localparam logic [7:0]  OPL_REG_FNUM_LO     = 8'hA0;
    localparam logic [7:0]  OPL_REG_KEY_FNUM_HI = 8'hB0;
    localparam logic [7:0]  OPL_REG_PAN         = 8'hC0;

    localparam logic [15:0] FM_TONE_LEVEL = 16'h2000;        // square amplitude

endpackage

//--- tb_sound.sv
//----------------------------------------------------------------------------
// random DSP, DMA, timer and tone traffic from seed 12 against a model;
// the FM model only covers timer 1, fnum, key and pan
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_sound;
    import sound_pkg::*;

    localparam int MAX_ACK_DELAY = 4;

    logic        clk;
    logic        rst_n;
    logic        irq;
    logic [3:0]  io_address;
    logic        io_read, io_write;
    logic [7:0]  io_writedata, io_readdata;
    logic [1:0]  fm_address;
    logic        fm_read, fm_write;
    logic [7:0]  fm_writedata, fm_readdata;
    logic        dma_soundblaster_req, dma_soundblaster_ack, dma_soundblaster_terminal;
    logic [7:0]  dma_soundblaster_readdata;
    logic [15:0] sample_l, sample_r;
    logic [8:0]  mgmt_address;
    logic        mgmt_write;
    logic [31:0] mgmt_writedata;

    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int watchdog_cycles = 0;                      // set once the random sizes are known

    sound i_sound (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                    // 8 ns period
    end

    //------------------------------------------------------------------------
    // model functions and bus tasks
    //------------------------------------------------------------------------
    function automatic logic [15:0] dsp_to_signed(input logic [7:0] b);
        int s;
        s = (int'(b) - 128) * 256 + int'(b);      // signed byte high, raw byte low
        return s[15:0];
    endfunction

    function automatic logic [15:0] mix_expect(input logic [15:0] dsp, input logic [15:0] fm);
        logic signed [15:0] quarter;
        logic signed [15:0] half;
        quarter = $signed(dsp) >>> 2;
        half    = $signed(fm) >>> 1;
        return quarter + half;                    // wraps at 16 bits
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d mismatches", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic io_wr(input logic [3:0] addr, input logic [7:0] data);
        @(negedge clk);
        io_address   = addr;
        io_writedata = data;
        io_write     = 1'b1;
        @(negedge clk);
        io_write = 1'b0;
    endtask

    task automatic io_rd(input logic [3:0] addr, output logic [7:0] data);
        @(negedge clk);
        io_address = addr;
        io_read    = 1'b1;
        #1 data = io_readdata;                    // combinational from the address
        @(negedge clk);
        io_read = 1'b0;
    endtask

    task automatic fm_wr(input logic [1:0] addr, input logic [7:0] data);
        @(negedge clk);
        fm_address   = addr;
        fm_writedata = data;
        fm_write     = 1'b1;
        @(negedge clk);
        fm_write = 1'b0;
    endtask

    task automatic fm_rd(input logic [1:0] addr, output logic [7:0] data);
        @(negedge clk);
        fm_address = addr;
        fm_read    = 1'b1;
        #1 data = fm_readdata;
        @(negedge clk);
        fm_read = 1'b0;
    endtask

    // both windows written in the same cycle
    task automatic both_wr(input logic [3:0] io_a, input logic [7:0] io_d,
                           input logic [1:0] fm_a, input logic [7:0] fm_d);
        @(negedge clk);
        io_address   = io_a;
        io_writedata = io_d;
        fm_address   = fm_a;
        fm_writedata = fm_d;
        io_write     = 1'b1;
        fm_write     = 1'b1;
        @(negedge clk);
        io_write = 1'b0;
        fm_write = 1'b0;
    endtask

    task automatic mgmt_wr(input logic [8:0] addr, input logic [31:0] data);
        @(negedge clk);
        mgmt_address   = addr;
        mgmt_writedata = data;
        mgmt_write     = 1'b1;
        @(negedge clk);
        mgmt_write = 1'b0;
    endtask

    task automatic wait_req(input int limit, output bit seen);
        int n;
        n = 0;
        while (!dma_soundblaster_req && n < limit) begin
            @(negedge clk);
            n++;
        end
        seen = dma_soundblaster_req;
        if (!seen) begin
            errors++;
            $display("no DMA request came within %0d cycles of the previous byte", limit);
        end
    endtask

    task automatic wait_sign_change(input bit use_left, input int limit, output int cycles);
        logic start_sign;
        logic [15:0] v;
        v = use_left ? sample_l : sample_r;
        start_sign = v[15];
        cycles = 0;
        while (v[15] == start_sign && cycles < limit) begin
            @(negedge clk);
            cycles++;
            v = use_left ? sample_l : sample_r;
        end
        if (v[15] == start_sign) begin
            errors++;
            $display("tone output kept its sign for %0d cycles", limit);
        end
    endtask

    // watchdog sized from the DMA, timer and reset lengths
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    //------------------------------------------------------------------------
    // stimulus
    //------------------------------------------------------------------------
    initial begin
        int seed;
        int dma_period, dma_len, tick_len, n_ticks, cycles, fnum0, fnum_io, delay;
        logic [7:0] t1_preset, rd, rd_fm, b;
        logic [1:0] pan;
        logic [15:0] lpos, lneg, rpos, rneg, act_pos, act_neg, act;
        bit seen, seen_pos, seen_neg;

        seed = 12;
        void'($urandom(seed));
        rst_n = 1'b0;
        io_address = '0;
        io_read = 1'b0;
        io_write = 1'b0;
        io_writedata = '0;
        fm_address = '0;
        fm_read = 1'b0;
        fm_write = 1'b0;
        fm_writedata = '0;
        dma_soundblaster_ack = 1'b0;
        dma_soundblaster_terminal = 1'b0;
        dma_soundblaster_readdata = '0;
        mgmt_address = '0;
        mgmt_write = 1'b0;
        mgmt_writedata = '0;

        dma_period = 3 + $urandom % 6;
        dma_len    = 2 + $urandom % 8;            // plays dma_len+1 bytes
        tick_len   = 4 + $urandom % 5;
        t1_preset  = 8'hF0 + $urandom % 9;
        fnum0      = 2 + $urandom % 4;
        fnum_io    = 8 + $urandom % 6;            // above fnum0 so the counter never wraps
        pan        = 2'd1 + $urandom % 3;
        watchdog_cycles = 4000 + PERIOD_80US_RESET
                        + (dma_len + 1) * (dma_period + MAX_ACK_DELAY + 8)
                        + (257 - t1_preset) * tick_len;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // test 1 checks the reset handshake
        io_wr(4'h6, 8'h01);
        io_wr(4'h6, 8'h00);
        io_rd(4'hE, rd);
        check("offset E bit 7 after reset pulse", rd[7], 1'b1);
        io_rd(4'hA, rd);
        check("reset ack byte", rd, DSP_RESET_ACK);
        io_rd(4'hE, rd);
        check("offset E bit 7 after ack read", rd[7], 1'b0);
        end_test(1, "dsp reset");

        // test 2 plays direct dac bytes with FM silent
        io_wr(4'hC, DSP_CMD_SPK_ON);
        repeat (8) begin
            b = $urandom;
            io_wr(4'hC, DSP_CMD_DAC);
            io_wr(4'hC, b);
            @(negedge clk);                       // mixer takes the pulse
            check("dac sample_l", sample_l, mix_expect(dsp_to_signed(b), 16'd0));
            check("dac sample_r", sample_r, mix_expect(dsp_to_signed(b), 16'd0));
        end
        io_wr(4'hC, DSP_CMD_SPK_OFF);
        @(negedge clk);
        check("sample_l with speaker off", sample_l, 16'd0);
        check("sample_r with speaker off", sample_r, 16'd0);
        end_test(2, "direct dac");

        // test 3 runs a single-cycle dma
        mgmt_wr(MGMT_ADDR_SAMPLE_PERIOD, dma_period);
        io_wr(4'hC, DSP_CMD_SPK_ON);
        io_wr(4'hC, DSP_CMD_DMA8);
        io_wr(4'hC, dma_len[7:0]);
        io_wr(4'hC, dma_len[15:8]);
        for (int i = 0; i <= dma_len; i++) begin
            wait_req(dma_period + 8, seen);
            if (!seen) break;
            delay = $urandom % (MAX_ACK_DELAY + 1);
            repeat (delay) @(negedge clk);        // late ack while req holds
            b = $urandom;
            dma_soundblaster_readdata = b;
            dma_soundblaster_ack      = 1'b1;
            @(negedge clk);
            dma_soundblaster_ack = 1'b0;
            check("irq after ack", irq, i == dma_len);
            @(negedge clk);
            check("dma sample_l", sample_l, mix_expect(dsp_to_signed(b), 16'd0));
            check("dma sample_r", sample_r, mix_expect(dsp_to_signed(b), 16'd0));
        end
        io_rd(4'hE, rd);
        check("irq after offset E read", irq, 1'b0);
        end_test(3, "dma playback");

        // test 4 lets timer 1 overflow
        mgmt_wr(MGMT_ADDR_80US, tick_len);
        repeat (PERIOD_80US_RESET + 2) @(negedge clk);   // old tick countdown drains
        fm_wr(2'd0, OPL_REG_TIMER1);
        fm_wr(2'd1, t1_preset);
        fm_wr(2'd0, OPL_REG_CTRL);
        fm_wr(2'd1, 8'h01);
        fm_address = 2'd0;
        #1;
        n_ticks = 256 - t1_preset;
        cycles  = 0;
        while (!fm_readdata[6] && cycles < n_ticks * tick_len + 20) begin
            @(negedge clk);
            cycles++;
        end
        check("timer 1 overflow in tick window",
              cycles >= (n_ticks - 1) * tick_len + 1 && cycles <= n_ticks * tick_len, 1);
        io_rd(4'h8, rd);
        fm_rd(2'd0, rd_fm);
        check("status at io offset 8", rd, 8'hC0);
        check("status at fm offset 0", rd_fm, 8'hC0);
        fm_wr(2'd1, 8'h80);                       // index still on control
        io_rd(4'h8, rd);
        fm_rd(2'd0, rd_fm);
        check("io status after flag clear", rd, 8'h00);
        check("fm status after flag clear", rd_fm, 8'h00);
        fm_wr(2'd1, 8'h00);
        end_test(4, "fm timer");

        // test 5 covers the panned tone and window priority
        io_wr(4'hC, DSP_CMD_SPK_OFF);
        @(negedge clk);
        io_wr(4'h0, OPL_REG_FNUM_LO);
        io_wr(4'h1, fnum0);
        fm_wr(2'd0, OPL_REG_PAN);
        fm_wr(2'd1, {2'b00, pan, 4'h0});
        io_wr(4'h8, OPL_REG_KEY_FNUM_HI);
        io_wr(4'h9, 8'h20);                       // key on
        lpos = pan[0] ? mix_expect(16'd0, FM_TONE_LEVEL) : 16'd0;
        lneg = pan[0] ? mix_expect(16'd0, -FM_TONE_LEVEL) : 16'd0;
        rpos = pan[1] ? mix_expect(16'd0, FM_TONE_LEVEL) : 16'd0;
        rneg = pan[1] ? mix_expect(16'd0, -FM_TONE_LEVEL) : 16'd0;
        act_pos  = pan[0] ? lpos : rpos;
        act_neg  = pan[0] ? lneg : rneg;
        seen_pos = 1'b0;
        seen_neg = 1'b0;
        repeat (4 * (fnum0 + 1) + 2) begin
            @(negedge clk);
            check("tone level left", sample_l == lpos || sample_l == lneg, 1);
            check("tone level right", sample_r == rpos || sample_r == rneg, 1);
            act = pan[0] ? sample_l : sample_r;
            if (act == act_pos) seen_pos = 1'b1;
            if (act == act_neg) seen_neg = 1'b1;
        end
        check("tone changed sign", seen_pos && seen_neg, 1);
        io_wr(4'h0, OPL_REG_FNUM_LO);
        both_wr(4'h1, fnum_io, 2'd1, fnum_io + 5);
        wait_sign_change(pan[0], 64, cycles);     // lines up on an edge
        wait_sign_change(pan[0], 64, cycles);
        check("half period after simultaneous writes", cycles, fnum_io + 1);
        io_wr(4'h0, OPL_REG_KEY_FNUM_HI);
        io_wr(4'h1, 8'h00);
        @(negedge clk);
        check("sample_l after key off", sample_l, 16'd0);
        check("sample_r after key off", sample_r, 16'd0);
        end_test(5, "tone and arbitration");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
